// File: uart_cfg_pkg.sv
package uart_cfg_pkg;

    // ----------------------------------------------------------------------
    // Frame geometry, 8N1 only
    // ----------------------------------------------------------------------
    localparam int data_bits  = 8;   // Data bits per frame
    localparam int frame_bits = 10;  // Start + data + stop

    // ----------------------------------------------------------------------
    // Line levels
    // ----------------------------------------------------------------------
    localparam logic line_idle       = 1'b1;  // Mark state between frames
    localparam logic start_bit_level = 1'b0;  // Space opens a frame
    localparam logic stop_bit_level  = 1'b1;  // Mark closes a frame

    // Defaults for the top-level parameters
    // Bit period in clk cycles, keep it even so mid-bit is exact
    localparam int default_clks_per_bit = 8;
    localparam int default_fifo_depth   = 4;  // Entries per FIFO

    // ----------------------------------------------------------------------
    // Transmit FSM states
    // ----------------------------------------------------------------------
    // tx_idle   line high, waiting for the FIFO
    // tx_start  driving the start bit
    // tx_data   shifting out eight data bits, LSB first
    // tx_stop   driving the stop bit, may chain straight into tx_start
    typedef enum logic [1:0] {
        tx_idle  = 2'b00,
        tx_start = 2'b01,
        tx_data  = 2'b10,
        tx_stop  = 2'b11
    } tx_state_t;

    // Encoding is fixed so that waveforms and the bound checks
    // see the same values on every tool

endpackage

// File: uart_frame_pkg.sv
package uart_frame_pkg;

    // ----------------------------------------------------------------------
    // Payload types
    // ----------------------------------------------------------------------

    // One byte on the line, width follows the frame geometry
    typedef logic [uart_cfg_pkg::data_bits-1:0] uart_byte_t;

    // Entry of the receive FIFO
    typedef struct packed {
        uart_byte_t data;         // Byte as sampled, LSB arrived first
        logic       frame_error;  // Stop bit sampled low
    } rx_frame_t;                 // 9 bits

    // ----------------------------------------------------------------------
    // Status word of the core
    // ----------------------------------------------------------------------
    // Overflow bits are sticky until reset
    // Empty bits come straight from the FIFO counters
    typedef struct packed {
        logic tx_busy;      // Transmitter not idle
        logic tx_overflow;  // Write to a full transmit FIFO seen
        logic rx_overflow;  // Frame lost, receive FIFO was full
        logic tx_empty;     // Nothing left to send
        logic rx_empty;     // rx_frame not valid
    } uart_status_t;        // 5 bits

    // Byte-wide and frame-wide payloads share one FIFO module,
    // the type is handed to it as a parameter

endpackage

// File: bit_timer.sv
`timescale 1ns/1ns

module bit_timer #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::default_clks_per_bit
)(
    input  logic clk,
    input  logic reset_n,
    input  logic run,       // Count while high, clear while low
    output logic bit_tick,  // Last cycle of each bit period
    output logic mid_tick   // Half period point, used for sampling
);

    // Counter width, at least one bit
    localparam int CNT_W = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam int LAST  = CLKS_PER_BIT - 1;
    localparam int MID   = CLKS_PER_BIT / 2 - 1;  // Last cycle of first half

    logic [CNT_W-1:0] cnt;  // Position inside the current bit

    // ----------------------------------------------------------------------
    // Period counter
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            cnt <= '0;
        end else if (!run || bit_tick) begin
            cnt <= '0;              // Restart, next bit begins at zero
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    // Ticks only while running so a stopped timer is silent
    assign bit_tick = run && (cnt == CNT_W'(LAST));
    assign mid_tick = run && (cnt == CNT_W'(MID));

endmodule

// File: sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter type payload_t  = uart_frame_pkg::uart_byte_t,
    parameter int  FIFO_DEPTH = uart_cfg_pkg::default_fifo_depth
)(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     push,       // Single-cycle write strobe
    input  payload_t push_data,
    input  logic     pop,        // Single-cycle read strobe
    output payload_t head,       // Oldest entry, valid while !empty
    output logic     empty,
    output logic     overflow    // Sticky, push seen while full
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    payload_t         mem [FIFO_DEPTH];  // Circular buffer
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;             // Entries held
    logic             full;
    logic             do_push;           // Accepted write
    logic             do_pop;            // Accepted read

    assign full    = (count == CNT_W'(FIFO_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;      // Full FIFO drops the write
    assign do_pop  = pop && !empty;      // Empty FIFO ignores the read

    // ----------------------------------------------------------------------
    // Pointers, count and overflow flag
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                // Wrap by compare, depth need not be a power of two
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;     // Both or neither
            endcase
            if (push && full) begin
                overflow <= 1'b1;            // Held until reset
            end
        end
    end

    // Storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    // First word fall through, head follows rd_ptr directly
    assign head = mem[rd_ptr];

endmodule

// File: uart_tx_controller.sv
`timescale 1ns/1ns

module uart_tx_controller #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::default_clks_per_bit
)(
    input  logic                       clk,
    input  logic                       reset_n,
    input  uart_frame_pkg::uart_byte_t fifo_head,   // Byte at the FIFO head
    input  logic                       fifo_empty,
    output logic                       fifo_pop,    // Pops and latches head
    output logic                       tx_serial,   // Serial line out
    output logic                       tx_busy,     // Frame in progress
    output logic                       tx_done      // Last cycle of stop bit
);

    localparam int BIT_CNT_W = $clog2(uart_cfg_pkg::data_bits);
    localparam int MSB       = uart_cfg_pkg::data_bits - 1;

    uart_cfg_pkg::tx_state_t    state;
    uart_cfg_pkg::tx_state_t    state_next;
    uart_frame_pkg::uart_byte_t shift_q;    // Bits still to send, LSB next
    logic [BIT_CNT_W-1:0]       bit_cnt;    // Data bit index
    logic                       last_bit;   // Bit 7 on the line
    logic                       bit_tick;   // End of the current bit

    // ----------------------------------------------------------------------
    // Bit timing
    // ----------------------------------------------------------------------
    // Runs in every non-idle state, wraps on bit_tick so chained
    // frames keep the exact period
    bit_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_bit_timer (
        .clk      (clk),
        .reset_n  (reset_n),
        .run      (state != uart_cfg_pkg::tx_idle),
        .bit_tick (bit_tick),
        .mid_tick ()               // Sampling point not needed on transmit
    );

    assign last_bit = (bit_cnt == BIT_CNT_W'(MSB));

    // Pop when idle, or at the end of a stop bit when more data waits
    assign fifo_pop = !fifo_empty &&
                      ((state == uart_cfg_pkg::tx_idle) ||
                       (state == uart_cfg_pkg::tx_stop && bit_tick));

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            uart_cfg_pkg::tx_idle: begin
                if (!fifo_empty) state_next = uart_cfg_pkg::tx_start;
            end
            uart_cfg_pkg::tx_start: begin
                if (bit_tick) state_next = uart_cfg_pkg::tx_data;
            end
            uart_cfg_pkg::tx_data: begin
                if (bit_tick && last_bit) state_next = uart_cfg_pkg::tx_stop;
            end
            uart_cfg_pkg::tx_stop: begin
                if (bit_tick) begin
                    // Back-to-back frames, no idle gap
                    state_next = fifo_empty ? uart_cfg_pkg::tx_idle
                                            : uart_cfg_pkg::tx_start;
                end
            end
            default: state_next = uart_cfg_pkg::tx_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= uart_cfg_pkg::tx_idle;
            bit_cnt <= '0;
        end else begin
            state <= state_next;
            if (state != uart_cfg_pkg::tx_data) begin
                bit_cnt <= '0;                      // Ready for next frame
            end else if (bit_tick) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Shift register, loaded with the popped byte
    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            shift_q <= fifo_head;
        end else if (state == uart_cfg_pkg::tx_data && bit_tick) begin
            shift_q <= {1'b0, shift_q[MSB:1]};      // LSB first
        end
    end

    // ----------------------------------------------------------------------
    // Line and status outputs
    // ----------------------------------------------------------------------
    always_comb begin
        case (state)
            uart_cfg_pkg::tx_start: tx_serial = uart_cfg_pkg::start_bit_level;
            uart_cfg_pkg::tx_data:  tx_serial = shift_q[0];
            uart_cfg_pkg::tx_stop:  tx_serial = uart_cfg_pkg::stop_bit_level;
            default:                tx_serial = uart_cfg_pkg::line_idle;
        endcase
    end

    assign tx_busy = (state != uart_cfg_pkg::tx_idle);
    assign tx_done = (state == uart_cfg_pkg::tx_stop) && bit_tick;  // One cycle

endmodule

// File: uart_rx_deserializer.sv
`timescale 1ns/1ns

module uart_rx_deserializer #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::default_clks_per_bit
)(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      rx_serial,  // Asynchronous line in
    output logic                      rx_push,    // One cycle per frame
    output uart_frame_pkg::rx_frame_t rx_data     // Valid with rx_push
);

    localparam int BIT_CNT_W = $clog2(uart_cfg_pkg::data_bits);
    localparam int MSB       = uart_cfg_pkg::data_bits - 1;

    typedef enum logic [1:0] {
        rx_idle,   // Waiting for a falling edge
        rx_start,  // Start bit re-checked at mid-bit
        rx_shift,  // Eight data bits
        rx_stop    // Stop bit with push at mid-bit
    } rx_state_t;

    rx_state_t                  state;
    rx_state_t                  state_next;
    logic [2:0]                 sync_q;    // Two sync flops plus edge history
    logic                       rx_bit;    // Synchronized line
    logic                       fall;      // High to low on the line
    uart_frame_pkg::uart_byte_t shift_q;   // Assembles the byte
    logic [BIT_CNT_W-1:0]       bit_cnt;
    logic                       bit_tick;
    logic                       mid_tick;

    // ----------------------------------------------------------------------
    // Synchronizer and edge detect
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            sync_q <= {3{uart_cfg_pkg::line_idle}};
        end else begin
            sync_q <= {sync_q[1:0], rx_serial};
        end
    end

    assign rx_bit = sync_q[1];
    assign fall   = sync_q[2] && !sync_q[1];

    // Timer starts from zero on the cycle after the edge
    bit_timer #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) u_bit_timer (
        .clk      (clk),
        .reset_n  (reset_n),
        .run      (state != rx_idle),
        .bit_tick (bit_tick),
        .mid_tick (mid_tick)
    );

    // ----------------------------------------------------------------------
    // FSM
    // ----------------------------------------------------------------------
    always_comb begin
        state_next = state;
        case (state)
            rx_idle:  if (fall) state_next = rx_start;
            rx_start: begin
                if (mid_tick && rx_bit != uart_cfg_pkg::start_bit_level) begin
                    state_next = rx_idle;           // Line went back high
                end else if (bit_tick) begin
                    state_next = rx_shift;
                end
            end
            rx_shift: if (bit_tick && bit_cnt == BIT_CNT_W'(MSB)) state_next = rx_stop;
            rx_stop:  if (mid_tick) state_next = rx_idle;  // Leave early for the next edge
            default:  state_next = rx_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= rx_idle;
            bit_cnt <= '0;
            rx_push <= 1'b0;
        end else begin
            state   <= state_next;
            rx_push <= (state == rx_stop) && mid_tick;
            if (state != rx_shift) bit_cnt <= '0;
            else if (bit_tick)     bit_cnt <= bit_cnt + 1'b1;
        end
    end

    // Byte assembly and frame capture
    always_ff @(posedge clk) begin
        if (state == rx_shift && mid_tick) begin
            shift_q <= {rx_bit, shift_q[MSB:1]};    // LSB arrives first
        end
        if (state == rx_stop && mid_tick) begin
            rx_data.data        <= shift_q;
            rx_data.frame_error <= (rx_bit != uart_cfg_pkg::stop_bit_level);
        end
    end

endmodule

// File: uart_core.sv
`timescale 1ns/1ns

module uart_core #(
    parameter int CLKS_PER_BIT = uart_cfg_pkg::default_clks_per_bit,
    parameter int FIFO_DEPTH   = uart_cfg_pkg::default_fifo_depth
)(
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         tx_wr,      // Write strobe
    input  uart_frame_pkg::uart_byte_t   tx_byte,
    input  logic                         rx_rd,      // Pop strobe
    input  logic                         rx_serial,
    output logic                         tx_serial,
    output logic                         tx_done,
    output uart_frame_pkg::rx_frame_t    rx_frame,   // Head of receive FIFO
    output uart_frame_pkg::uart_status_t status
);

    uart_frame_pkg::uart_byte_t tx_head;
    uart_frame_pkg::rx_frame_t  rx_push_data;
    logic tx_empty, tx_pop, tx_overflow, tx_busy;
    logic rx_push, rx_empty, rx_overflow;

    // ----------------------------------------------------------------------
    // Transmit path
    // ----------------------------------------------------------------------
    sync_fifo #(.payload_t(uart_frame_pkg::uart_byte_t), .FIFO_DEPTH(FIFO_DEPTH)) u_tx_fifo (
        .clk(clk), .reset_n(reset_n),
        .push(tx_wr), .push_data(tx_byte),
        .pop(tx_pop), .head(tx_head), .empty(tx_empty), .overflow(tx_overflow)
    );

    uart_tx_controller #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx (
        .clk(clk), .reset_n(reset_n),
        .fifo_head(tx_head), .fifo_empty(tx_empty), .fifo_pop(tx_pop),
        .tx_serial(tx_serial), .tx_busy(tx_busy), .tx_done(tx_done)
    );

    // ----------------------------------------------------------------------
    // Receive path
    // ----------------------------------------------------------------------
    uart_rx_deserializer #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_rx (
        .clk(clk), .reset_n(reset_n),
        .rx_serial(rx_serial), .rx_push(rx_push), .rx_data(rx_push_data)
    );

    sync_fifo #(.payload_t(uart_frame_pkg::rx_frame_t), .FIFO_DEPTH(FIFO_DEPTH)) u_rx_fifo (
        .clk(clk), .reset_n(reset_n),
        .push(rx_push), .push_data(rx_push_data),
        .pop(rx_rd), .head(rx_frame), .empty(rx_empty), .overflow(rx_overflow)
    );

    // Status word
    assign status = '{tx_busy: tx_busy, tx_overflow: tx_overflow,
                      rx_overflow: rx_overflow, tx_empty: tx_empty, rx_empty: rx_empty};

endmodule

// File: tb_uart_asserts.sv
`timescale 1ns/1ns

module tb_uart_asserts #(
    parameter int CLKS_PER_BIT = 8
)(
    input logic                    clk,
    input logic                    reset_n,
    input uart_cfg_pkg::tx_state_t state,
    input logic                    tx_serial,
    input logic                    fifo_pop,
    input logic                    fifo_empty,
    input logic                    tx_done
);

    int start_low;  // Cycles of start bit seen low so far

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            start_low <= 0;
        end else if (state == uart_cfg_pkg::tx_start && !tx_serial) begin
            start_low <= start_low + 1;
        end else begin
            start_low <= 0;                 // Cleared outside the start bit
        end
    end

    // Idle line is mark
    a_idle_high: assert property (@(posedge clk) disable iff (!reset_n)
        state == uart_cfg_pkg::tx_idle |-> tx_serial)
        else $error("tx_serial low while the transmitter is idle");

    // Full start bit on leaving tx_start
    a_start_len: assert property (@(posedge clk) disable iff (!reset_n)
        (state == uart_cfg_pkg::tx_data && $past(state) == uart_cfg_pkg::tx_start)
        |-> start_low == CLKS_PER_BIT)
        else $error("start bit did not stay low for a full bit period");

    a_pop_nonempty: assert property (@(posedge clk) disable iff (!reset_n)
        fifo_pop |-> !fifo_empty)
        else $error("transmit FIFO popped while empty");

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        tx_done |=> !tx_done)
        else $error("tx_done held longer than one cycle");

endmodule

bind uart_tx_controller tb_uart_asserts #(.CLKS_PER_BIT(CLKS_PER_BIT)) u_tx_asserts (
    .clk(clk), .reset_n(reset_n), .state(state), .tx_serial(tx_serial),
    .fifo_pop(fifo_pop), .fifo_empty(fifo_empty), .tx_done(tx_done)
);

// File: tb_uart_core.sv
`timescale 1ns/1ns

module tb_uart_core;

    localparam int CLKS_PER_BIT = 8;
    localparam int FIFO_DEPTH   = 4;
    localparam int FRAME_CLKS   = uart_cfg_pkg::frame_bits * CLKS_PER_BIT;
    localparam int MAX_CYCLES   = 60 * FRAME_CLKS + 2000;  // 60 frames plus slack

    logic clk       = 1'b0;
    logic reset_n   = 1'b0;
    logic tx_wr     = 1'b0;
    logic rx_rd     = 1'b0;
    logic inject    = 1'b0;  // Mux select, high plays a testbench frame
    logic inj_line  = 1'b1;  // Injected line, idle high
    logic tx_serial, tx_done, rx_serial;
    uart_frame_pkg::uart_byte_t   tx_byte = '0;
    uart_frame_pkg::rx_frame_t    rx_frame;
    uart_frame_pkg::uart_status_t status;

    // Reference model
    uart_frame_pkg::rx_frame_t  exp_q[$];   // Frames due at rx_frame
    uart_frame_pkg::uart_byte_t line_q[$];  // Bytes due on tx_serial
    uart_frame_pkg::uart_byte_t line_byte;  // Byte under the line monitor
    logic [31:0] rng_state;
    int cycles     = 0;
    int done_count = 0;
    int tx_frames  = 0;

    assign rx_serial = inject ? inj_line : tx_serial;  // Loopback or injection

    uart_core #(.CLKS_PER_BIT(CLKS_PER_BIT), .FIFO_DEPTH(FIFO_DEPTH)) u_uart_core (
        .clk(clk), .reset_n(reset_n), .tx_wr(tx_wr), .tx_byte(tx_byte), .rx_rd(rx_rd),
        .rx_serial(rx_serial), .tx_serial(tx_serial), .tx_done(tx_done),
        .rx_frame(rx_frame), .status(status)
    );

    always #20 clk = ~clk;  // 40 ns period

    // ----------------------------------------------------------------------
    // Helpers and compare tasks
    // ----------------------------------------------------------------------
    function automatic logic [31:0] next_rand();
        rng_state ^= rng_state << 13;   // xorshift32
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t ns: %s got %b expected %b",
                                $time, name, got, exp));
    endtask

    task automatic check_frame(input uart_frame_pkg::rx_frame_t got,
                               input uart_frame_pkg::rx_frame_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t ns: rx_frame got %h expected %h",
                                $time, got, exp));
    endtask

    task automatic check_status(input uart_frame_pkg::uart_status_t got,
                                input uart_frame_pkg::uart_status_t exp);
        if (got !== exp)
            abort_run($sformatf("mismatch at %0t ns: status got %b expected %b",
                                $time, got, exp));
    endtask

    // Called on a falling edge, strobe left high for the next call
    task automatic write_byte(input uart_frame_pkg::uart_byte_t b, input bit accepted);
        uart_frame_pkg::rx_frame_t f;
        @(negedge clk);
        tx_wr   = 1'b1;
        tx_byte = b;
        f.data        = b;
        f.frame_error = 1'b0;
        if (accepted) begin
            line_q.push_back(b);
            exp_q.push_back(f);
            tx_frames++;
        end
    endtask

    task automatic stop_write();
        @(negedge clk);
        tx_wr = 1'b0;
    endtask

    // 8N1 frame on the injected line, stop level chosen by caller
    task automatic play_frame(input uart_frame_pkg::uart_byte_t b, input logic stop);
        uart_frame_pkg::rx_frame_t f;
        logic [9:0]                bits;
        f.data        = b;
        f.frame_error = !stop;   // Low stop bit flags an error
        exp_q.push_back(f);
        bits = {stop, b, 1'b0};
        for (int i = 0; i < uart_cfg_pkg::frame_bits; i++) begin
            inj_line = bits[i];  // LSB first after start
            repeat (CLKS_PER_BIT) @(negedge clk);
        end
        inj_line = 1'b1;
        repeat (12) @(negedge clk);   // Idle gap
    endtask

    task automatic wait_drained();
        while (exp_q.size() != 0 || line_q.size() != 0) @(negedge clk);
    endtask

    // ----------------------------------------------------------------------
    // Monitors
    // ----------------------------------------------------------------------
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES)
            abort_run($sformatf("timeout, run passed %0d cycles", MAX_CYCLES));
    end

    always @(negedge clk) begin
        if (reset_n && tx_done === 1'b1) done_count++;
    end

    // Receive reader, pops every frame that shows up
    always @(negedge clk) begin
        rx_rd <= 1'b0;
        if (reset_n && !status.rx_empty) begin
            if (exp_q.size() == 0) abort_run("received a frame that was never sent");
            check_frame(rx_frame, exp_q.pop_front());
            rx_rd <= 1'b1;
        end
    end

    // Line format, mid-bit samples from each start edge
    always begin
        @(negedge tx_serial);
        if (line_q.size() == 0) abort_run("start bit on tx_serial with no byte written");
        line_byte = line_q.pop_front();
        repeat (CLKS_PER_BIT / 2) @(posedge clk);
        @(negedge clk);
        check_bit("tx_serial start bit", tx_serial, 1'b0);
        for (int i = 0; i < uart_cfg_pkg::data_bits; i++) begin
            repeat (CLKS_PER_BIT) @(negedge clk);
            check_bit($sformatf("tx_serial data bit %0d", i), tx_serial, line_byte[i]);
        end
        repeat (CLKS_PER_BIT) @(negedge clk);
        check_bit("tx_serial stop bit", tx_serial, 1'b1);
    end

    // ----------------------------------------------------------------------
    // Test sequence
    // ----------------------------------------------------------------------
    initial begin
        uart_frame_pkg::uart_status_t exp_st;
        int                           seen;
        rng_state = 32'hb462;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset_n = 1'b1;

        // Reset values
        @(negedge clk);
        check_bit("tx_serial", tx_serial, 1'b1);
        check_bit("tx_done", tx_done, 1'b0);
        exp_st = '{tx_busy: 1'b0, tx_overflow: 1'b0, rx_overflow: 1'b0,
                   tx_empty: 1'b1, rx_empty: 1'b1};
        check_status(status, exp_st);

        // Overflow, one popped at once, four held, sixth dropped
        for (int i = 0; i < 6; i++) write_byte(8'(next_rand()), i < 5);
        stop_write();
        check_bit("tx_overflow", status.tx_overflow, 1'b1);
        wait_drained();

        // Loopback with random gaps
        for (int i = 0; i < 40; i++) begin
            repeat (next_rand() % 16) @(negedge clk);
            while (!status.tx_empty) @(negedge clk);
            write_byte(8'(next_rand()), 1'b1);
            stop_write();
        end
        wait_drained();

        // Burst up to the FIFO depth
        while (status.tx_busy) @(negedge clk);
        for (int i = 0; i < FIFO_DEPTH; i++) write_byte(8'(next_rand()), 1'b1);
        stop_write();
        seen = 0;
        while (seen < FIFO_DEPTH) begin
            check_bit("tx_busy", status.tx_busy, 1'b1);
            if (tx_done) seen++;
            @(negedge clk);
        end
        check_bit("tx_busy", status.tx_busy, 1'b0);   // Idle right after last done
        check_bit("tx_empty", status.tx_empty, 1'b1);
        wait_drained();

        // Injected frames, stop level random, first one forced low
        inject = 1'b1;
        for (int i = 0; i < 10; i++)
            play_frame(8'(next_rand()), (i == 0) ? 1'b0 : 1'(next_rand()));
        wait_drained();
        inject = 1'b0;
        repeat (2 * FRAME_CLKS) @(negedge clk);  // Quiet, catches stray frames

        exp_st = '{tx_busy: 1'b0, tx_overflow: 1'b1, rx_overflow: 1'b0,
                   tx_empty: 1'b1, rx_empty: 1'b1};
        check_status(status, exp_st);
        if (done_count != tx_frames) begin
            abort_run($sformatf("tx_done pulsed %0d times for %0d frames",
                                done_count, tx_frames));
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

// File: flist.f
uart_cfg_pkg.sv
uart_frame_pkg.sv
bit_timer.sv
sync_fifo.sv
uart_tx_controller.sv
uart_rx_deserializer.sv
uart_core.sv
tb_uart_asserts.sv
tb_uart_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the UART testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f flist.f --top-module tb_uart_core \
    -Mdir obj_dir -o sim_uart > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_uart > sim.log 2>&1
grep -q "Simulation finished: PASS" sim.log \
    && { echo "PASS"; exit 0; } \
    || { echo "FAIL, see sim.log"; exit 1; }
